// File: cache_top.f
+incdir+include
design/cache_pkg.sv
design/cache_request_latch.sv
design/cache_way.sv
design/cache_way_select.sv
design/cache_control.sv
design/cache_top.sv
verification/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns --top-module cache_tb \
    -f cache_top.f -o cache_sim > build.log 2>&1 \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: verification/cache_tb.sv
// directed testbench for the two-way cache with cpu requests, a 3-cycle memory model
// and a flat reference memory; run through the file list as top module cache_tb
`timescale 1ns/1ns
`default_nettype none

`include "cache_params.svh"

module cache_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int MEM_LATENCY    = 3;
    localparam int ACCESS_LIMIT   = 64;
    // all accesses times the worst miss with writeback, then doubled
    localparam int TOTAL_ACCESSES = 52;
    localparam int MISS_CYCLES    = 14;
    localparam int WATCHDOG_NS    =
        (RESET_CYCLES + TOTAL_ACCESSES * MISS_CYCLES) * CLK_PERIOD * 2;

    logic     clk = 1'b0;
    logic     reset_i;
    logic     req_valid;
    cpu_req_t req;
    logic     resp_valid;
    line_t    rdata;
    logic     pmem_read;
    logic     pmem_write;
    addr_t    pmem_addr;
    line_t    pmem_wdata;
    line_t    pmem_rdata = '0;
    logic     pmem_resp = 1'b0;

    // memory model state and its log of served requests
    line_t mem_lines [addr_t];
    int    mem_wait;
    int    mem_reads;
    int    mem_writes;
    addr_t op_addr_q [$];
    logic  op_write_q [$];
    line_t op_data_q [$];

    // flat reference of what the cpu should see
    line_t ref_lines [addr_t];

    logic [15:0] lfsr_state = 16'd37;
    int          check_cnt;
    int          error_cnt;
    int          log_checked;

    cache_top dut_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .rdata_o      (rdata),
        .pmem_read_o  (pmem_read),
        .pmem_write_o (pmem_write),
        .pmem_addr_o  (pmem_addr),
        .pmem_wdata_o (pmem_wdata),
        .pmem_rdata_i (pmem_rdata),
        .pmem_resp_i  (pmem_resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // unwritten memory where every word mixes the whole line address
    function automatic line_t default_line(input addr_t a);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ (32'h0101_0101 * (w + 1));
        end
        return l;
    endfunction

    function automatic addr_t align(input addr_t a);
        return {a[31:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic addr_t line_addr(input tag_t t, input index_t s, input logic [4:0] off);
        return {t, s, off};
    endfunction

    function automatic line_t mem_line(input addr_t a);
        return mem_lines.exists(a) ? mem_lines[a] : default_line(a);
    endfunction

    function automatic line_t ref_line(input addr_t a);
        return ref_lines.exists(a) ? ref_lines[a] : default_line(a);
    endfunction

    // enabled bytes come from the new line and the rest stay
    function automatic line_t merge_bytes(input line_t old_line, input line_t new_line,
                                          input byte_en_t be);
        line_t l;
        l = old_line;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (be[b]) begin
                l[b*8 +: 8] = new_line[b*8 +: 8];
            end
        end
        return l;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = rand_bits(32);
        end
        return l;
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            error_cnt++;
            $display("%s: saw %0d, expected %0d", what, got, exp);
        end
    endtask

    // every line written to memory must equal the reference line
    task automatic check_pmem_writes();
        while (log_checked < op_addr_q.size()) begin
            if (op_write_q[log_checked]) begin
                check_line("pmem_wdata_o", op_data_q[log_checked],
                           ref_line(op_addr_q[log_checked]));
            end
            log_checked++;
        end
    endtask

    // memory model answering each held request three cycles after it appears
    always @(posedge clk) begin
        if (reset_i) begin
            pmem_resp <= 1'b0;
            mem_wait  <= 0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;
            mem_wait  <= 0;
        end else if (pmem_read || pmem_write) begin
            if (mem_wait < MEM_LATENCY - 1) begin
                mem_wait <= mem_wait + 1;
            end else begin
                pmem_resp <= 1'b1;
                op_addr_q.push_back(pmem_addr);
                op_write_q.push_back(pmem_write);
                op_data_q.push_back(pmem_wdata);
                if (pmem_write) begin
                    mem_writes++;
                    mem_lines[pmem_addr] = pmem_wdata;
                end else begin
                    mem_reads++;
                    pmem_rdata <= mem_line(pmem_addr);
                end
            end
        end
    end

    // one request is a strobe and then a wait for the response strobe
    task automatic access(input addr_t addr, input logic write, input line_t wdata,
                          input byte_en_t be, output line_t data, output int cycles);
        cpu_req_t r;
        logic     done;
        r.addr  = addr;
        r.wdata = wdata;
        r.be    = be;
        r.write = write;
        data    = '0;
        cycles  = 0;
        done    = 1'b0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
        // cycles counted from the edge that samples the strobe
        while (!done && cycles < ACCESS_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (resp_valid) begin
                data = rdata;
                done = 1'b1;
            end
        end
        if (!done) begin
            error_cnt++;
            $display("no response to the request at address %h", addr);
        end
        check_pmem_writes();
    endtask

    task automatic read_and_check(input addr_t addr);
        line_t data;
        int    cycles;
        access(addr, 1'b0, '0, '0, data, cycles);
        check_line("rdata_o", data, ref_line(align(addr)));
    endtask

    task automatic write_bytes(input addr_t addr, input line_t wdata, input byte_en_t be);
        line_t data;
        int    cycles;
        access(addr, 1'b1, wdata, be, data, cycles);
        ref_lines[align(addr)] = merge_bytes(ref_line(align(addr)), wdata, be);
    endtask

    task automatic test_first_read(input addr_t addr);
        int reads0;
        @(negedge clk);
        check_flag("resp_valid_o", resp_valid, 1'b0);
        check_flag("pmem_read_o", pmem_read, 1'b0);
        check_flag("pmem_write_o", pmem_write, 1'b0);
        reads0 = mem_reads;
        read_and_check(addr);
        check_count("memory reads for the first read of a line", mem_reads - reads0, 1);
        check_addr("pmem_addr_o", op_addr_q[op_addr_q.size() - 1], align(addr));
    endtask

    task automatic test_hit_latency(input addr_t addr);
        line_t data;
        int    cycles;
        int    ops0;
        ops0 = op_addr_q.size();
        access(addr, 1'b0, '0, '0, data, cycles);
        check_count("cycles from strobe to response on a read hit", cycles, 2);
        check_line("rdata_o", data, ref_line(align(addr)));
        check_count("memory requests on a read hit", op_addr_q.size() - ops0, 0);
    endtask

    task automatic test_write_merge(input addr_t addr);
        line_t    old_line;
        line_t    wdata;
        line_t    data;
        byte_en_t be;
        int       cycles;
        old_line = ref_line(align(addr));
        wdata    = rand_line();
        be       = 32'h8000_1021;
        write_bytes(addr, wdata, be);
        access(addr, 1'b0, '0, '0, data, cycles);
        check_line("rdata_o", data, merge_bytes(old_line, wdata, be));
    endtask

    // in set 2 A and B fill both ways and A is touched last so C evicts dirty B
    task automatic test_lru_writeback();
        addr_t a_addr;
        addr_t b_addr;
        addr_t c_addr;
        int    n0;
        a_addr = line_addr(24'h000021, 3'd2, 5'd0);
        b_addr = line_addr(24'h000022, 3'd2, 5'd0);
        c_addr = line_addr(24'h000023, 3'd2, 5'd0);
        read_and_check(a_addr);
        write_bytes(b_addr, rand_line(), 32'h0f0f_00ff);
        read_and_check(a_addr);
        n0 = op_addr_q.size();
        read_and_check(c_addr);
        check_count("memory requests when C evicts B", op_addr_q.size() - n0, 2);
        if (op_addr_q.size() - n0 == 2) begin
            check_flag("pmem_write_o", op_write_q[n0], 1'b1);
            check_addr("pmem_addr_o", op_addr_q[n0], b_addr);
            check_line("pmem_wdata_o", op_data_q[n0], ref_line(b_addr));
            check_flag("pmem_write_o", op_write_q[n0 + 1], 1'b0);
            check_addr("pmem_addr_o", op_addr_q[n0 + 1], c_addr);
        end
    endtask

    task automatic test_clean_eviction();
        int writes0;
        writes0 = mem_writes;
        for (int t = 0; t < 4; t++) begin
            read_and_check(line_addr(24'h000051 + 24'(t), 3'd5, 5'd8));
        end
        check_count("memory writes after clean evictions", mem_writes - writes0, 0);
    endtask

    // four tags in each of sets 6 and 7 keep lines getting evicted
    task automatic test_random_mix();
        logic [31:0] op_bits;
        logic [31:0] off_bits;
        addr_t       addr;
        for (int i = 0; i < 40; i++) begin
            op_bits  = rand_bits(4);
            off_bits = rand_bits(5);
            addr     = line_addr({22'd1, op_bits[1:0]}, {2'b11, op_bits[2]}, off_bits[4:0]);
            if (op_bits[3]) begin
                write_bytes(addr, rand_line(), rand_bits(32));
            end else begin
                read_and_check(addr);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset_i   <= 1'b1;
        req_valid <= 1'b0;
        req       <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        test_first_read(32'h0000_100c);
        test_hit_latency(32'h0000_100c);
        test_write_merge(32'h0000_1000);
        test_lru_writeback();
        test_clean_eviction();
        test_random_mix();
        $display("checks: %0d  errors: %0d  memory reads: %0d  memory writes: %0d",
                 check_cnt, error_cnt, mem_reads, mem_writes);
        if (error_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cache_top.sv
// two-way write-back cache with a line-wide cpu port and a held-request
// memory port; latch, ways, selector and FSM are wired here
`timescale 1ns/1ns
`default_nettype none

`include "cache_params.svh"

module cache_top import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    // cpu side
    input  logic     req_valid_i,
    input  cpu_req_t req_i,
    output logic     resp_valid_o,
    output line_t    rdata_o,
    // memory side
    output logic     pmem_read_o,
    output logic     pmem_write_o,
    output addr_t    pmem_addr_o,
    output line_t    pmem_wdata_o,
    input  line_t    pmem_rdata_i,
    input  logic     pmem_resp_i
);

    cpu_req_t    req_q;
    tag_t        req_tag;
    index_t      req_index;
    logic        start;
    way_ctrl_t   way_ctrl;
    way_mask_t   victim_mask;
    way_status_t way_status [`CACHE_WAYS];
    logic        hit;
    logic        victim_dirty;
    addr_t       wb_addr;
    addr_t       fill_addr;
    logic        write_back;

    cache_request_latch u_latch (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_o       (req_q),
        .tag_o       (req_tag),
        .index_o     (req_index),
        .start_o     (start)
    );

    // identical ways each told whether it is the victim
    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        cache_way u_way (
            .clk         (clk),
            .reset_i     (reset_i),
            .tag_i       (req_tag),
            .index_i     (req_index),
            .req_i       (req_q),
            .ctrl_i      (way_ctrl),
            .victim_i    (victim_mask[g]),
            .fill_data_i (pmem_rdata_i),
            .status_o    (way_status[g])
        );
    end

    cache_way_select u_select (
        .clk            (clk),
        .reset_i        (reset_i),
        .index_i        (req_index),
        .status_i       (way_status),
        .req_i          (req_q),
        .victim_o       (victim_mask),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .rdata_o        (rdata_o),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (pmem_wdata_o),
        .fill_addr_o    (fill_addr)
    );

    cache_control u_control (
        .clk            (clk),
        .reset_i        (reset_i),
        .start_i        (start),
        .write_i        (req_q.write),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .pmem_resp_i    (pmem_resp_i),
        .ctrl_o         (way_ctrl),
        .write_back_o   (write_back),
        .pmem_read_o    (pmem_read_o),
        .pmem_write_o   (pmem_write_o),
        .resp_valid_o   (resp_valid_o)
    );

    // victim address while writing back and the request line otherwise
    assign pmem_addr_o = write_back ? wb_addr : fill_addr;

endmodule

`default_nettype wire

// File: design/cache_control.sv
// miss-handling FSM running tag compare, optional dirty writeback and line fill
// before comparing again; drives way strobes, memory requests and the cpu response
`timescale 1ns/1ns
`default_nettype none

module cache_control import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      start_i,
    input  logic      write_i,
    input  logic      hit_i,
    input  logic      victim_dirty_i,
    input  logic      pmem_resp_i,
    output way_ctrl_t ctrl_o,
    output logic      write_back_o,
    output logic      pmem_read_o,
    output logic      pmem_write_o,
    output logic      resp_valid_o
);

    cache_state_t state_q;
    cache_state_t state_d;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                // a hit answers now and a miss needs memory
                if (hit_i) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty_i) begin
                    state_d = ST_WRITE_BACK;
                end else begin
                    state_d = ST_FILL;
                end
            end
            ST_WRITE_BACK: begin
                if (pmem_resp_i) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                // line lands in the victim way at this edge
                if (pmem_resp_i) begin
                    state_d = ST_COMPARE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // way strobes
    assign ctrl_o.compare_en = (state_q == ST_COMPARE);
    assign ctrl_o.write_hit  = (state_q == ST_COMPARE) && write_i;
    assign ctrl_o.fill       = (state_q == ST_FILL) && pmem_resp_i;

    // memory requests held for the whole state
    assign write_back_o = (state_q == ST_WRITE_BACK);
    assign pmem_write_o = (state_q == ST_WRITE_BACK);
    assign pmem_read_o  = (state_q == ST_FILL);

    // response in the compare cycle that hits
    assign resp_valid_o = (state_q == ST_COMPARE) && hit_i;

    // memory only answers a pending request
    a_resp_with_request: assert property (@(posedge clk) disable iff (reset_i)
        pmem_resp_i |-> (pmem_read_o || pmem_write_o))
        else $error("memory response without a pending request");

    // requester may not strobe again before the response
    a_start_when_idle: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> (state_q == ST_IDLE))
        else $error("request strobe while busy");

endmodule

`default_nettype wire

// File: design/cache_way_select.sv
// combines the per-way results into hit and read data, LRU victim choice,
// victim dirty bit and the memory addresses for writeback and fill
`timescale 1ns/1ns
`default_nettype none

`include "cache_params.svh"

module cache_way_select import cache_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  index_t      index_i,
    input  way_status_t status_i [`CACHE_WAYS],
    input  cpu_req_t    req_i,
    output way_mask_t   victim_o,
    output logic        hit_o,
    output logic        victim_dirty_o,
    output line_t       rdata_o,
    output addr_t       wb_addr_o,
    output line_t       wb_data_o,
    output addr_t       fill_addr_o
);

    localparam int SETS  = 2**`CACHE_INDEX_W;
    localparam int WAY_W = $clog2(`CACHE_WAYS);

    // one lru bit per set naming the way to evict
    logic [SETS-1:0]  lru_q;
    way_mask_t        hits;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;

    // collect hits and find the hitting way
    always_comb begin
        hits    = '0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hits[w] = status_i[w].hit;
            if (status_i[w].hit) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit_o   = |hits;
    assign rdata_o = status_i[hit_way].data;

    // victim from the lru bit of this set
    assign victim_way     = lru_q[index_i];
    assign victim_o       = way_mask_t'(1) << victim_way;
    assign victim_dirty_o = status_i[victim_way].dirty;

    // writeback target rebuilt from the victim tag
    assign wb_addr_o = {status_i[victim_way].tag, index_i, {`CACHE_OFFSET_W{1'b0}}};
    assign wb_data_o = status_i[victim_way].data;

    // fill target is the request address with the offset dropped
    assign fill_addr_o = {req_i.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W],
                          {`CACHE_OFFSET_W{1'b0}}};

    // on a hit the other way becomes the next victim
    always_ff @(posedge clk) begin
        if (reset_i) begin
            lru_q <= '0;
        end else if (hit_o) begin
            lru_q[index_i] <= ~hit_way;
        end
    end

    // a line lives in one way only
    a_single_hit: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(hits))
        else $error("more than one way hit");

endmodule

`default_nettype wire

// File: design/cache_way.sv
// one cache way with tag, valid, dirty and data arrays for all sets,
// the tag compare for the addressed set and its byte write enables
`timescale 1ns/1ns
`default_nettype none

`include "cache_params.svh"

module cache_way import cache_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  tag_t        tag_i,
    input  index_t      index_i,
    input  cpu_req_t    req_i,
    input  way_ctrl_t   ctrl_i,
    input  logic        victim_i,
    input  line_t       fill_data_i,
    output way_status_t status_o
);

    localparam int SETS = 2**`CACHE_INDEX_W;

    // storage
    tag_t              tag_q   [SETS];
    line_t             data_q  [SETS];
    logic [SETS-1:0]   valid_q;
    logic [SETS-1:0]   dirty_q;

    logic     hit;
    logic     fill_en;
    logic     write_en;
    byte_en_t write_mask;
    line_t    write_src;
    line_t    line_next;

    // compare only while the controller says so
    assign hit = ctrl_i.compare_en && valid_q[index_i] && (tag_q[index_i] == tag_i);

    // fill goes to the victim way only
    assign fill_en  = ctrl_i.fill && victim_i;
    assign write_en = ctrl_i.write_hit && hit;

    // whole line on fill and cpu byte mask on write hit
    always_comb begin
        if (fill_en) begin
            write_mask = '1;
            write_src  = fill_data_i;
        end else if (write_en) begin
            write_mask = req_i.be;
            write_src  = req_i.wdata;
        end else begin
            write_mask = '0;
            write_src  = req_i.wdata;
        end
    end

    // merge new bytes over the stored line
    always_comb begin
        line_next = data_q[index_i];
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (write_mask[b]) begin
                line_next[b*8 +: 8] = write_src[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|write_mask) begin
            data_q[index_i] <= line_next;
        end
        if (fill_en) begin
            tag_q[index_i] <= tag_i;
        end
    end

    // fill sets valid and clears dirty while a write hit sets dirty
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= 1'b0;
        end else if (write_en) begin
            dirty_q[index_i] <= 1'b1;
        end
    end

    assign status_o.hit   = hit;
    assign status_o.dirty = dirty_q[index_i];
    assign status_o.tag   = tag_q[index_i];
    assign status_o.data  = data_q[index_i];

    // controller must never fill while this way reports a hit
    a_no_hit_on_fill: assert property (@(posedge clk) disable iff (reset_i)
        !(hit && ctrl_i.fill))
        else $error("way hit during fill");

endmodule

`default_nettype wire

// File: design/cache_request_latch.sv
// holds one cpu request from its strobe until the next one
// and splits the held address into the tag and set fields used by the ways
`timescale 1ns/1ns
`default_nettype none

`include "cache_params.svh"

module cache_request_latch import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     req_valid_i,
    input  cpu_req_t req_i,
    output cpu_req_t req_o,
    output tag_t     tag_o,
    output index_t   index_o,
    output logic     start_o
);

    cpu_req_t req_q;
    logic     start_q;

    // request payload loaded only on the strobe
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            req_q <= req_i;
        end
    end

    // start follows the capture edge by one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_q <= 1'b0;
        end else begin
            start_q <= req_valid_i;
        end
    end

    assign req_o   = req_q;
    assign start_o = start_q;

    // tag is everything above the set index
    assign tag_o = req_q.addr[`CACHE_ADDR_W-1 -: $bits(tag_t)];

    // set index sits right above the line offset
    assign index_o = req_q.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
// shared field vectors, request, strobe and status structs
// and the controller state encoding of the cache
`default_nettype none

package cache_pkg;

    `include "cache_params.svh"

    // address fields
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-`CACHE_OFFSET_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;

    // line payload and its byte mask
    typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
    typedef logic [`CACHE_LINE_BYTES-1:0] byte_en_t;

    // one bit per way
    typedef logic [`CACHE_WAYS-1:0] way_mask_t;

    // cpu request as held by the latch
    typedef struct packed {
        addr_t    addr;
        line_t    wdata;
        byte_en_t be;
        logic     write;
    } cpu_req_t;

    // controller strobes shared by all ways
    typedef struct packed {
        logic compare_en;
        logic write_hit;
        logic fill;
    } way_ctrl_t;

    // per-way view of the addressed set
    typedef struct packed {
        logic  hit;
        logic  dirty;
        tag_t  tag;
        line_t data;
    } way_status_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITE_BACK,
        ST_FILL
    } cache_state_t;

endpackage

`default_nettype wire

// File: include/cache_params.svh
// size macros for the two-way write-back cache
// included by the package and by every RTL block that sizes arrays or fields
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address width
`define CACHE_ADDR_W 32

// byte offset inside a 32-byte line
`define CACHE_OFFSET_W 5

// set index for 8 sets
`define CACHE_INDEX_W 3

// two ways per set since the LRU is a single bit
`define CACHE_WAYS 2

// bytes per line with one byte enable each
`define CACHE_LINE_BYTES 32

`endif
